// ==== include/isb_config.svh ====
`ifndef ISB_CONFIG_SVH
`define ISB_CONFIG_SVH

// address widths
`define ISB_ADDR_W 16
`define ISB_SA_W 6

// training unit, one entry per tracked pc
`define ISB_TU_ENTRIES 4

// physical to structural table, direct mapped on low pa bits
`define ISB_PS_ENTRIES 32

// structural to physical table, each entry covers consecutive sas
`define ISB_SP_ENTRIES 8
`define ISB_SP_SLOTS 4

// stream allocation in the structural space
`define ISB_STREAM_LEN 16
`define ISB_SA_LIMIT 32

// saturated confidence
`define ISB_CTR_MAX 3

`endif

// ==== src/isb_pkg.sv ====
`default_nettype none

`include "isb_config.svh"

package isb_pkg;

    // meaningful widths
    typedef logic [`ISB_ADDR_W-1:0] isb_pa_t;
    typedef logic [`ISB_ADDR_W-1:0] isb_pc_t;
    typedef logic [`ISB_SA_W-1:0] isb_sa_t;
    typedef logic [$clog2(`ISB_CTR_MAX + 1)-1:0] isb_ctr_t;

    typedef struct packed {
        isb_pc_t pc;
        isb_pa_t pa;
    } isb_access_t;

    // wishbone classic request, data carries the access
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        isb_access_t dat;
    } isb_wb_req_t;

    typedef struct packed {
        logic hit;
        isb_pa_t last_pa;
    } isb_tu_hit_t;

    typedef struct packed {
        logic valid;
        isb_sa_t sa;
        isb_ctr_t ctr;
    } isb_ps_entry_t;

    typedef struct packed {
        logic en;
        isb_pa_t pa;
        isb_sa_t sa;
        isb_ctr_t ctr;
    } isb_ps_wr_t;

    typedef struct packed {
        logic en;
        isb_sa_t sa;
        isb_pa_t pa;
    } isb_sp_wr_t;

    typedef struct packed {
        logic valid;
        isb_pa_t pa;
    } isb_prefetch_t;

endpackage

`default_nettype wire

// ==== src/isb_wb_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module isb_wb_port (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire isb_pkg::isb_wb_req_t   wb_req_i,
    output logic                     wb_ack_o,
    output logic                     accept_o,
    input  wire isb_pkg::isb_prefetch_t pred_i,
    output isb_pkg::isb_prefetch_t   prefetch_o
);

    logic ack_q;

    // take a request only in the cycle before its ack
    assign accept_o = wb_req_i.cyc && wb_req_i.stb && wb_req_i.we && !ack_q;
    assign wb_ack_o = ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept_o;
        end
    end

    // one cycle pulse, aligned with ack
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prefetch_o <= '0;
        end else begin
            prefetch_o.valid <= accept_o && pred_i.valid;
            if (accept_o) begin
                prefetch_o.pa <= pred_i.pa;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/isb_training_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "isb_config.svh"

module isb_training_unit (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    accept_i,
    input  wire isb_pkg::isb_access_t access_i,
    output isb_pkg::isb_tu_hit_t   hit_o
);

    import isb_pkg::*;

    localparam int N     = `ISB_TU_ENTRIES;
    localparam int IDX_W = $clog2(N);

    logic [N-1:0]     valid_q;
    isb_pc_t          pc_q [N];
    isb_pa_t          last_q [N];
    // age 0 is most recent, N-1 is the victim
    logic [IDX_W-1:0] age_q [N];

    logic             hit;
    logic [IDX_W-1:0] hit_idx;
    logic [IDX_W-1:0] victim_idx;
    logic [IDX_W-1:0] wr_idx;

    always_comb begin
        hit        = 1'b0;
        hit_idx    = '0;
        victim_idx = '0;
        for (int i = 0; i < N; i++) begin
            if (valid_q[i] && pc_q[i] == access_i.pc) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
            if (age_q[i] == IDX_W'(N - 1)) begin
                victim_idx = IDX_W'(i);
            end
        end
    end

    assign wr_idx       = hit ? hit_idx : victim_idx;
    assign hit_o.hit     = hit;
    assign hit_o.last_pa = last_q[hit_idx];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < N; i++) begin
                age_q[i] <= IDX_W'(i);
            end
        end else if (accept_i) begin
            valid_q[wr_idx] <= 1'b1;
            // entries younger than the written one get one step older
            for (int i = 0; i < N; i++) begin
                if (IDX_W'(i) == wr_idx) begin
                    age_q[i] <= '0;
                end else if (age_q[i] < age_q[wr_idx]) begin
                    age_q[i] <= age_q[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            pc_q[wr_idx]   <= access_i.pc;
            last_q[wr_idx] <= access_i.pa;
        end
    end

endmodule

`default_nettype wire

// ==== src/isb_ps_amc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "isb_config.svh"

module isb_ps_amc (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire isb_pkg::isb_pa_t       rd_a_i,
    input  wire isb_pkg::isb_pa_t       rd_b_i,
    output isb_pkg::isb_ps_entry_t   ent_a_o,
    output isb_pkg::isb_ps_entry_t   ent_b_o,
    input  wire isb_pkg::isb_ps_wr_t    wr_i [2]
);

    import isb_pkg::*;

    localparam int N     = `ISB_PS_ENTRIES;
    localparam int IDX_W = $clog2(N);

    logic [N-1:0] valid_q;
    // full pa kept as tag
    isb_pa_t      tag_q [N];
    isb_sa_t      sa_q [N];
    isb_ctr_t     ctr_q [N];

    function automatic isb_ps_entry_t lookup(input isb_pa_t pa);
        logic [IDX_W-1:0] idx;
        idx          = pa[IDX_W-1:0];
        lookup.valid = valid_q[idx] && (tag_q[idx] == pa);
        lookup.sa    = sa_q[idx];
        lookup.ctr   = ctr_q[idx];
    endfunction

    // table contents read inside lookup must wake this block too
    always_comb begin
        ent_a_o = lookup(rd_a_i);
        ent_b_o = lookup(rd_b_i);
    end

    // port 1 is applied last and wins an index clash
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wr_i[w].en) begin
                    valid_q[wr_i[w].pa[IDX_W-1:0]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wr_i[w].en) begin
                tag_q[wr_i[w].pa[IDX_W-1:0]] <= wr_i[w].pa;
                sa_q[wr_i[w].pa[IDX_W-1:0]]  <= wr_i[w].sa;
                ctr_q[wr_i[w].pa[IDX_W-1:0]] <= wr_i[w].ctr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/isb_sp_amc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "isb_config.svh"

module isb_sp_amc (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire isb_pkg::isb_sp_wr_t    wr_i [2],
    input  wire                      pred_req_i,
    input  wire isb_pkg::isb_sa_t       pred_sa_i,
    output isb_pkg::isb_prefetch_t   pred_o
);

    import isb_pkg::*;

    localparam int N      = `ISB_SP_ENTRIES;
    localparam int S      = `ISB_SP_SLOTS;
    localparam int IDX_W  = $clog2(N);
    localparam int SLOT_W = $clog2(S);
    localparam int TAG_W  = `ISB_SA_W - SLOT_W;

    // sa splits into tag | index | slot, the tag being sa / slots
    logic [TAG_W-1:0] tag_q [N];
    logic [TAG_W-1:0] tag_d [N];
    logic [S-1:0]     slot_v_q [N];
    logic [S-1:0]     slot_v_d [N];
    isb_pa_t          pa_q [N][S];

    always_comb begin
        logic [IDX_W-1:0]  idx;
        logic [SLOT_W-1:0] slot;
        logic [TAG_W-1:0]  tag;
        tag_d    = tag_q;
        slot_v_d = slot_v_q;
        for (int w = 0; w < 2; w++) begin
            idx  = wr_i[w].sa[SLOT_W +: IDX_W];
            slot = wr_i[w].sa[SLOT_W-1:0];
            tag  = wr_i[w].sa[`ISB_SA_W-1:SLOT_W];
            if (wr_i[w].en) begin
                if (tag_d[idx] != tag) begin
                    // re-tag drops the other slots
                    tag_d[idx]    = tag;
                    slot_v_d[idx] = '0;
                end
                slot_v_d[idx][slot] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < N; i++) begin
                tag_q[i]    <= '0;
                slot_v_q[i] <= '0;
            end
        end else begin
            tag_q    <= tag_d;
            slot_v_q <= slot_v_d;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wr_i[w].en) begin
                pa_q[wr_i[w].sa[SLOT_W +: IDX_W]][wr_i[w].sa[SLOT_W-1:0]] <= wr_i[w].pa;
            end
        end
    end

    // prediction sees the table as it was before this edge
    assign pred_o.valid = pred_req_i
                       && slot_v_q[pred_sa_i[SLOT_W +: IDX_W]][pred_sa_i[SLOT_W-1:0]]
                       && tag_q[pred_sa_i[SLOT_W +: IDX_W]] == pred_sa_i[`ISB_SA_W-1:SLOT_W];
    assign pred_o.pa    = pa_q[pred_sa_i[SLOT_W +: IDX_W]][pred_sa_i[SLOT_W-1:0]];

endmodule

`default_nettype wire

// ==== src/isb_mapper.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "isb_config.svh"

module isb_mapper (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      accept_i,
    input  wire isb_pkg::isb_access_t   access_i,
    input  wire isb_pkg::isb_tu_hit_t   tu_hit_i,
    input  wire isb_pkg::isb_ps_entry_t ent_a_i,
    input  wire isb_pkg::isb_ps_entry_t ent_b_i,
    output isb_pkg::isb_ps_wr_t      ps_wr_o [2],
    output isb_pkg::isb_sp_wr_t      sp_wr_o [2],
    output logic                     pred_req_o,
    output isb_pkg::isb_sa_t         pred_sa_o
);

    import isb_pkg::*;

    localparam isb_ctr_t CTR_MAX    = isb_ctr_t'(`ISB_CTR_MAX);
    localparam isb_sa_t  STREAM_LEN = isb_sa_t'(`ISB_STREAM_LEN);

    isb_sa_t  next_sa_q;
    logic     train;
    logic     alloc;
    isb_sa_t  sa_a_next;
    // A side always gets a fresh mapping
    logic     a_map;
    isb_sa_t  a_sa;
    // B side is either a remap or a counter update in place
    logic     b_wr;
    logic     b_remap;
    isb_sa_t  b_sa;
    isb_ctr_t b_ctr;

    function automatic logic in_space(input isb_sa_t sa);
        in_space = sa < `ISB_SA_LIMIT;
    endfunction

    assign train     = accept_i && tu_hit_i.hit && (tu_hit_i.last_pa != access_i.pa);
    assign sa_a_next = ent_a_i.sa + 1'b1;

    always_comb begin
        alloc   = 1'b0;
        a_map   = 1'b0;
        a_sa    = next_sa_q;
        b_wr    = 1'b0;
        b_remap = 1'b0;
        b_sa    = ent_b_i.sa;
        b_ctr   = ent_b_i.ctr - 1'b1;
        if (train) begin
            b_wr = 1'b1;
            case ({ent_a_i.valid, ent_b_i.valid})
                2'b00, 2'b01: begin
                    // new stream for A, B follows unless it holds on
                    alloc = 1'b1;
                    a_map = 1'b1;
                    if (!ent_b_i.valid || ent_b_i.ctr == isb_ctr_t'(1)) begin
                        b_remap = 1'b1;
                        b_sa    = next_sa_q + 1'b1;
                        b_ctr   = CTR_MAX;
                    end
                end
                2'b10: begin
                    b_remap = 1'b1;
                    b_sa    = sa_a_next;
                    b_ctr   = CTR_MAX;
                end
                default: begin
                    if (ent_b_i.sa == sa_a_next) begin
                        b_ctr = (ent_b_i.ctr == CTR_MAX) ? CTR_MAX : ent_b_i.ctr + 1'b1;
                    end else if (ent_b_i.ctr == isb_ctr_t'(1)) begin
                        b_remap = 1'b1;
                        b_sa    = sa_a_next;
                        b_ctr   = CTR_MAX;
                    end
                end
            endcase
        end
    end

    // every write is dropped outside the structural space
    always_comb begin
        ps_wr_o[0] = '{en: a_map && in_space(a_sa), pa: tu_hit_i.last_pa, sa: a_sa, ctr: CTR_MAX};
        sp_wr_o[0] = '{en: a_map && in_space(a_sa), sa: a_sa, pa: tu_hit_i.last_pa};
        ps_wr_o[1] = '{en: b_wr && in_space(b_sa), pa: access_i.pa, sa: b_sa, ctr: b_ctr};
        sp_wr_o[1] = '{en: b_remap && in_space(b_sa), sa: b_sa, pa: access_i.pa};
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            next_sa_q <= '0;
        end else if (alloc && in_space(next_sa_q)) begin
            next_sa_q <= next_sa_q + STREAM_LEN;
        end
    end

    // degree 1, next slot after B
    assign pred_req_o = ent_b_i.valid;
    assign pred_sa_o  = ent_b_i.sa + 1'b1;

endmodule

`default_nettype wire

// ==== src/isb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module isb_top (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire isb_pkg::isb_wb_req_t wb_req_i,
    output logic                   wb_ack_o,
    output isb_pkg::isb_prefetch_t prefetch_o
);

    import isb_pkg::*;

    logic          accept;
    isb_tu_hit_t   tu_hit;
    isb_ps_entry_t ent_a;
    isb_ps_entry_t ent_b;
    isb_ps_wr_t    ps_wr [2];
    isb_sp_wr_t    sp_wr [2];
    logic          pred_req;
    isb_sa_t       pred_sa;
    isb_prefetch_t pred;

    isb_wb_port wb_port_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_req_i   (wb_req_i),
        .wb_ack_o   (wb_ack_o),
        .accept_o   (accept),
        .pred_i     (pred),
        .prefetch_o (prefetch_o)
    );

    isb_training_unit training_unit_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .accept_i (accept),
        .access_i (wb_req_i.dat),
        .hit_o    (tu_hit)
    );

    // A is the pc's last address, B the address of this access
    isb_ps_amc ps_amc_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .rd_a_i  (tu_hit.last_pa),
        .rd_b_i  (wb_req_i.dat.pa),
        .ent_a_o (ent_a),
        .ent_b_o (ent_b),
        .wr_i    (ps_wr)
    );

    isb_sp_amc sp_amc_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr_i       (sp_wr),
        .pred_req_i (pred_req),
        .pred_sa_i  (pred_sa),
        .pred_o     (pred)
    );

    isb_mapper mapper_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .accept_i   (accept),
        .access_i   (wb_req_i.dat),
        .tu_hit_i   (tu_hit),
        .ent_a_i    (ent_a),
        .ent_b_i    (ent_b),
        .ps_wr_o    (ps_wr),
        .sp_wr_o    (sp_wr),
        .pred_req_o (pred_req),
        .pred_sa_o  (pred_sa)
    );

endmodule

`default_nettype wire

// ==== tests/isb_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module isb_properties (
    input wire                         clk,
    input wire                         rst_n_i,
    input wire isb_pkg::isb_wb_req_t   wb_req_i,
    input wire                         wb_ack_o,
    input wire isb_pkg::isb_prefetch_t prefetch_o
);

    logic req_seen;

    assign req_seen = wb_req_i.cyc && wb_req_i.stb;

    // one ack per request, never back to back
    ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb_ack_o high for two cycles in a row");

    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_ack_o |-> $past(req_seen))
        else $error("wb_ack_o without cyc and stb in the cycle before");

    // prefetch pulse rides on the ack cycle
    pf_with_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        prefetch_o.valid |-> wb_ack_o)
        else $error("prefetch valid outside an ack cycle");

endmodule

bind isb_top isb_properties props_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wb_req_i   (wb_req_i),
    .wb_ack_o   (wb_ack_o),
    .prefetch_o (prefetch_o)
);

`default_nettype wire

// ==== tests/isb_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module isb_tb;

    import isb_pkg::*;

    // one access and the prefetch expected with its ack
    typedef struct packed {
        isb_pc_t pc;
        isb_pa_t pa;
        logic    pf_valid;
        isb_pa_t pf_pa;
    } row_t;

    logic          clk;
    logic          rst_n_i;
    isb_wb_req_t   wb_req;
    logic          wb_ack;
    isb_prefetch_t prefetch;

    row_t rows [$];
    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   cycle_limit = 0;
    logic ack_prev = 1'b0;
    logic req_prev = 1'b0;

    isb_top dut_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_req_i   (wb_req),
        .wb_ack_o   (wb_ack),
        .prefetch_o (prefetch)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run exceeded %0d cycles waiting for an ack", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // bus timing as the master sees it, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (wb_ack === 1'b1 && ack_prev) begin
                $display("%0t: wb_ack_o stayed high for two cycles in a row", $time);
                errors++;
            end
            if (wb_ack === 1'b1 && !req_prev) begin
                $display("%0t: wb_ack_o came without a request in the cycle before", $time);
                errors++;
            end
            if (prefetch.valid === 1'b1 && wb_ack !== 1'b1) begin
                $display("%0t: prefetch_o.valid was high outside an ack cycle", $time);
                errors++;
            end
        end
        ack_prev = (wb_ack === 1'b1);
        req_prev = wb_req.cyc && wb_req.stb;
    end

    task automatic add_row(input isb_pc_t pc, input isb_pa_t pa,
                           input logic pf_valid, input isb_pa_t pf_pa);
        row_t r;
        r.pc       = pc;
        r.pa       = pa;
        r.pf_valid = pf_valid;
        r.pf_pa    = pf_pa;
        rows.push_back(r);
    endtask

    task automatic flag_mismatch(input string sig, input logic [15:0] expected,
                                 input logic [15:0] actual);
        $display("[ERROR] %0t %s expected %h got %h", $time, sig, expected, actual);
        errors++;
    endtask

    task automatic load_table();
        // stream 0x101 -> 0x202 -> 0x303 at sa 0..2
        add_row(16'h0001, 16'h0101, 1'b0, 16'h0000);
        add_row(16'h0001, 16'h0202, 1'b0, 16'h0000);
        add_row(16'h0001, 16'h0303, 1'b0, 16'h0000);
        add_row(16'h0002, 16'h0101, 1'b1, 16'h0202);
        add_row(16'h0002, 16'h0202, 1'b1, 16'h0303);
        // same address again, nothing trained
        add_row(16'h0002, 16'h0202, 1'b1, 16'h0303);
        // 0x505 gets sa 16, 0x202 loses confidence step by step
        add_row(16'h0003, 16'h0505, 1'b0, 16'h0000);
        add_row(16'h0003, 16'h0202, 1'b1, 16'h0303);
        add_row(16'h0003, 16'h0505, 1'b0, 16'h0000);
        add_row(16'h0003, 16'h0202, 1'b1, 16'h0303);
        add_row(16'h0003, 16'h0505, 1'b0, 16'h0000);
        // counter at 1, so 0x202 moves to sa 17
        add_row(16'h0003, 16'h0202, 1'b1, 16'h0303);
        add_row(16'h0004, 16'h0505, 1'b1, 16'h0202);
        // structural space full, pair dropped
        add_row(16'h0005, 16'h0606, 1'b0, 16'h0000);
        add_row(16'h0005, 16'h0707, 1'b0, 16'h0000);
        add_row(16'h0006, 16'h0606, 1'b0, 16'h0000);
        // pc 1 pushed out by four newer pcs
        add_row(16'h0001, 16'h0303, 1'b0, 16'h0000);
        add_row(16'h0002, 16'h0909, 1'b0, 16'h0000);
        add_row(16'h0003, 16'h0a0a, 1'b0, 16'h0000);
        add_row(16'h0004, 16'h0b0b, 1'b0, 16'h0000);
        add_row(16'h0005, 16'h0c0c, 1'b0, 16'h0000);
        add_row(16'h0001, 16'h0d0d, 1'b0, 16'h0000);
        add_row(16'h0006, 16'h0303, 1'b0, 16'h0000);
    endtask

    initial begin
        int waits;
        wb_req  = '0;
        rst_n_i = 1'b0;
        load_table();
        cycle_limit = 20 * rows.size() + 50;
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        @(negedge clk);
        checks++;
        if (wb_ack !== 1'b0) begin
            flag_mismatch("wb_ack_o", 16'h0, {15'h0, wb_ack});
        end
        checks++;
        if (prefetch.valid !== 1'b0) begin
            flag_mismatch("prefetch_o.valid", 16'h0, {15'h0, prefetch.valid});
        end

        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            wb_req.cyc    = 1'b1;
            wb_req.stb    = 1'b1;
            wb_req.we     = 1'b1;
            wb_req.dat.pc = rows[i].pc;
            wb_req.dat.pa = rows[i].pa;
            waits = 0;
            do begin
                @(negedge clk);
                waits++;
            end while (wb_ack !== 1'b1);

            // accepting edge then ack
            checks++;
            if (waits != 2) begin
                $display("row %0d: ack came %0d half cycles into the request instead of 2",
                         i, waits);
                errors++;
            end
            checks++;
            if (prefetch.valid !== rows[i].pf_valid) begin
                flag_mismatch("prefetch_o.valid", {15'h0, rows[i].pf_valid},
                              {15'h0, prefetch.valid});
            end
            if (rows[i].pf_valid) begin
                checks++;
                if (prefetch.pa !== rows[i].pf_pa) begin
                    flag_mismatch("prefetch_o.pa", rows[i].pf_pa, prefetch.pa);
                end
            end
        end

        // bus idle, no stray ack or prefetch
        @(posedge clk);
        #1;
        wb_req = '0;
        repeat (3) begin
            @(negedge clk);
            checks++;
            if (wb_ack !== 1'b0) begin
                flag_mismatch("wb_ack_o", 16'h0, {15'h0, wb_ack});
            end
            checks++;
            if (prefetch.valid !== 1'b0) begin
                flag_mismatch("prefetch_o.valid", 16'h0, {15'h0, prefetch.valid});
            end
        end
        @(posedge clk);

        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== isb_top.f ====
+incdir+include
src/isb_pkg.sv
src/isb_wb_port.sv
src/isb_training_unit.sv
src/isb_ps_amc.sv
src/isb_sp_amc.sv
src/isb_mapper.sv
src/isb_top.sv
tests/isb_properties.sv
tests/isb_tb.sv
